// ==== filelist.f ====
+incdir+tests
logic/exec_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/execute_stage.sv
logic/exec_pipe_top.sv
tests/exec_pipe_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with verilator, runs it into sim.log and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f filelist.f --top-module exec_pipe_tb -o exec_pipe_sim \
  || { echo "build failed"; exit 1; }
./obj_dir/exec_pipe_sim > sim.log 2>&1
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation passed"
exit 0

// ==== tests/exec_model.svh ====
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// ####################################################################
// architectural state and expected results
// ####################################################################

logic [xlen-1:0]       model_regs [0:(2**addr_width)-1];  // entry zero is never used.
int                    exp_edge_q [$];  // rising edge that samples the strobe.
logic [addr_width-1:0] exp_rd_q [$];
logic [xlen-1:0]       exp_data_q [$];
logic [31:0]           lfsr_state = 32'h427;

// galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit.
function automatic logic [31:0] take_bits(input int count);
  logic [31:0] bits;
  bits = '0;
  for (int i = 0; i < count; i++) begin
    bits = {bits[30:0], lfsr_state[0]};
    if (lfsr_state[0]) begin
      lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
    end else begin
      lfsr_state = lfsr_state >> 1;
    end
  end
  return bits;
endfunction

function automatic logic [xlen-1:0] alu_reference(
  input alu_op_t         op,
  input logic [xlen-1:0] a,
  input logic [xlen-1:0] b
);
  logic [4:0]      sh;
  logic [xlen-1:0] r;
  logic            lt;
  sh = b[4:0];
  r  = '0;
  case (op)
    alu_add:  r = a + b;
    alu_sub:  r = a + ~b + 1'b1;  // two's complement subtract.
    alu_and:  r = a & b;
    alu_or:   r = a | b;
    alu_xor:  r = a ^ b;
    alu_sll:  r = a << sh;
    alu_srl:  r = a >> sh;
    alu_sra:  r = (a >> sh) | (a[xlen-1] ? ~({xlen{1'b1}} >> sh) : '0);
    alu_slt: begin
      lt   = (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : (a < b);  // sign bits decide first.
      r[0] = lt;
    end
    alu_sltu: r[0] = (a < b);
    default:  r = '0;
  endcase
  return r;
endfunction

// runs one operation in program order and queues its writeback.
function automatic void predict_writeback(
  input alu_op_t               op,
  input logic [addr_width-1:0] rd,
  input logic [addr_width-1:0] rs1,
  input logic [addr_width-1:0] rs2,
  input logic [imm_width-1:0]  imm,
  input logic                  use_imm,
  input int                    issue_edge
);
  logic [xlen-1:0] a;
  logic [xlen-1:0] b;
  logic [xlen-1:0] r;
  a = (rs1 == '0) ? '0 : model_regs[rs1];
  if (use_imm) begin
    b = {{(xlen-imm_width){imm[imm_width-1]}}, imm};
  end else begin
    b = (rs2 == '0) ? '0 : model_regs[rs2];
  end
  r = alu_reference(op, a, b);
  if (rd != '0) begin
    model_regs[rd] = r;
  end
  exp_edge_q.push_back(issue_edge + 2);
  exp_rd_q.push_back(rd);
  exp_data_q.push_back(r);
endfunction

`endif

// ==== tests/exec_pipe_tb.sv ====
`timescale 1ns/1ns

module exec_pipe_tb import exec_pkg::*; ();

  localparam int addr_width      = 4;
  localparam int reset_cycles    = 8;
  localparam int directed_cycles = 160;
  localparam int random_cycles   = 300;
  localparam int watchdog_cycles = reset_cycles + directed_cycles + random_cycles + 40;

  typedef logic [addr_width-1:0] reg_addr_t;

  logic                  clock = 1'b0;
  logic                  rst_n;
  logic                  issue_valid;
  alu_op_t               issue_op;
  reg_addr_t             issue_rd;
  reg_addr_t             issue_rs1;
  reg_addr_t             issue_rs2;
  logic [imm_width-1:0]  issue_imm;
  logic                  issue_use_imm;
  logic                  wb_valid;
  reg_addr_t             wb_rd;
  logic [xlen-1:0]       wb_data;
  int                    edge_count = 0;

  exec_pipe_top #(
    .addr_width (addr_width)
  ) u_exec_pipe_top (
    .clock         (clock),
    .rst_n         (rst_n),
    .issue_valid   (issue_valid),
    .issue_op      (issue_op),
    .issue_rd      (issue_rd),
    .issue_rs1     (issue_rs1),
    .issue_rs2     (issue_rs2),
    .issue_imm     (issue_imm),
    .issue_use_imm (issue_use_imm),
    .wb_valid      (wb_valid),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data)
  );

  `include "exec_model.svh"

  always #5 clock = ~clock;

  // ####################################################################
  // checking
  // ####################################################################

  task automatic stop_on_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      $display("Error: %0t ns %s got %h expected %h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_data(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] exp);
    if (got !== exp) begin
      $display("Error: %0t ns %s got %h expected %h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  // outputs are read before this edge updates them.
  always @(posedge clock) begin
    edge_count = edge_count + 1;
    if (rst_n) begin
      if ((exp_edge_q.size() != 0) && (exp_edge_q[0] <= edge_count)) begin
        if (wb_valid !== 1'b1) begin
          $display("missing writeback for the operation issued at edge %0d", exp_edge_q[0] - 2);
          stop_on_failure();
        end else begin
          check_addr("wb_rd", wb_rd, exp_rd_q[0]);
          check_data("wb_data", wb_data, exp_data_q[0]);
          void'(exp_edge_q.pop_front());
          void'(exp_rd_q.pop_front());
          void'(exp_data_q.pop_front());
        end
      end else if (wb_valid !== 1'b0) begin
        $display("wb_valid high at %0t ns with no result expected", $time);
        stop_on_failure();
      end
    end
  end

  initial begin
    #(watchdog_cycles * 10);
    $display("watchdog expired before all results arrived");
    stop_on_failure();
  end

  // ####################################################################
  // stimulus
  // ####################################################################

  task automatic send_op(input alu_op_t op, input reg_addr_t rd, input reg_addr_t rs1,
                         input reg_addr_t rs2, input logic [imm_width-1:0] imm,
                         input logic use_imm);
    @(negedge clock);
    issue_valid   = 1'b1;
    issue_op      = op;
    issue_rd      = rd;
    issue_rs1     = rs1;
    issue_rs2     = rs2;
    issue_imm     = imm;
    issue_use_imm = use_imm;
    predict_writeback(op, rd, rs1, rs2, imm, use_imm, edge_count + 1);  // sampled next edge.
  endtask

  task automatic idle_cycle();
    @(negedge clock);
    issue_valid = 1'b0;  // payload stays, so stale fields linger.
  endtask

  task automatic send_random_op();
    logic [31:0] op_bits;
    logic [31:0] rd_bits;
    logic [31:0] rs1_bits;
    logic [31:0] rs2_bits;
    logic [31:0] imm_bits;
    logic [31:0] sel_bits;
    op_bits  = take_bits(4);
    rd_bits  = take_bits(addr_width);
    rs1_bits = take_bits(addr_width);
    rs2_bits = take_bits(addr_width);
    imm_bits = take_bits(imm_width);
    sel_bits = take_bits(1);
    send_op(alu_op_t'(op_bits[3:0] % 4'd10), rd_bits[addr_width-1:0],
            rs1_bits[addr_width-1:0], rs2_bits[addr_width-1:0],
            imm_bits[imm_width-1:0], sel_bits[0]);
  endtask

  initial begin
    logic [31:0] bits;
    alu_op_t     op;
    issue_valid   = 1'b0;
    issue_op      = alu_add;
    issue_rd      = '0;
    issue_rs1     = '0;
    issue_rs2     = '0;
    issue_imm     = '0;
    issue_use_imm = 1'b0;
    rst_n         = 1'b0;
    repeat (reset_cycles) @(negedge clock);
    rst_n = 1'b1;
    repeat (4) idle_cycle();  // no strobe before the first issue.

    for (int r = 1; r < 2 ** addr_width; r++) begin
      bits = take_bits(imm_width);
      send_op(alu_add, reg_addr_t'(r), '0, '0, bits[imm_width-1:0], 1'b1);
    end

    // operands for the operation sweep.
    send_op(alu_add, 4'd1, '0, '0, 12'h800, 1'b1);  // -2048.
    send_op(alu_add, 4'd2, '0, '0, 12'h7ff, 1'b1);
    send_op(alu_add, 4'd3, '0, '0, 12'h005, 1'b1);
    for (int k = 0; k < 10; k++) begin
      op = alu_op_t'(k);
      send_op(op, 4'd10, 4'd1, 4'd2, 12'h000, 1'b0);
      send_op(op, 4'd11, 4'd2, 4'd1, 12'h000, 1'b0);
      send_op(op, 4'd12, 4'd1, 4'd3, 12'hffd, 1'b1);
      send_op(op, 4'd13, 4'd1, 4'd3, 12'h025, 1'b0);
    end

    // consumer at distance one to four from its producer.
    for (int d = 1; d <= 4; d++) begin
      bits = take_bits(imm_width);
      send_op(alu_add, 4'd5, '0, '0, bits[imm_width-1:0], 1'b1);
      repeat (d - 1) idle_cycle();
      send_op(alu_add, 4'd6, 4'd5, 4'd5, 12'h000, 1'b0);
    end
    send_op(alu_add, 4'd7, '0, '0, 12'h111, 1'b1);
    send_op(alu_add, 4'd7, '0, '0, 12'h222, 1'b1);
    send_op(alu_xor, 4'd8, 4'd7, 4'd2, 12'h000, 1'b0);  // younger 0x222 must win.
    send_op(alu_sub, 4'd8, 4'd7, 4'd2, 12'h000, 1'b0);

    // register zero as destination and source.
    send_op(alu_add, '0, 4'd2, '0, 12'h123, 1'b1);
    send_op(alu_or, 4'd9, '0, '0, 12'h000, 1'b0);
    send_op(alu_or, 4'd9, '0, 4'd2, 12'h000, 1'b0);
    send_op(alu_add, 4'd9, 4'd2, '0, 12'h000, 1'b0);

    for (int n = 0; n < random_cycles; n++) begin
      bits = take_bits(2);
      if (bits[1:0] == 2'b00) begin
        idle_cycle();
      end else begin
        send_random_op();
      end
    end

    idle_cycle();
    while (exp_edge_q.size() != 0) begin
      @(negedge clock);
    end
    repeat (4) idle_cycle();  // no late strobes.
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== logic/exec_pipe_top.sv ====
`timescale 1ns/1ns

module exec_pipe_top import exec_pkg::*; #(
  parameter int addr_width = 4  // 4 for rv32e, 5 for the full file.
) (
  input  logic                  clock,
  input  logic                  rst_n,
  // issue side.
  input  logic                  issue_valid,
  input  alu_op_t               issue_op,
  input  logic [addr_width-1:0] issue_rd,
  input  logic [addr_width-1:0] issue_rs1,
  input  logic [addr_width-1:0] issue_rs2,
  input  logic [imm_width-1:0]  issue_imm,
  input  logic                  issue_use_imm,
  // writeback side.
  output logic                  wb_valid,
  output logic [addr_width-1:0] wb_rd,
  output logic [xlen-1:0]       wb_data
);

  // ####################################################################
  // internal nets
  // ####################################################################

  logic [xlen-1:0]       rdata1;
  logic [xlen-1:0]       rdata2;

  logic                  ex_valid;
  logic [addr_width-1:0] ex_rd;
  logic [xlen-1:0]       ex_result;

  // ####################################################################
  // register file
  // ####################################################################

  // the writeback strobe doubles as the write port.
  register_file #(
    .addr_width (addr_width)
  ) u_register_file (
    .clock     (clock),
    .rs1       (issue_rs1),
    .rs2       (issue_rs2),
    .ex_valid  (ex_valid),
    .ex_rd     (ex_rd),
    .ex_result (ex_result),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .rdata1    (rdata1),
    .rdata2    (rdata2)
  );

  // ####################################################################
  // execute and writeback
  // ####################################################################

  execute_stage #(
    .addr_width (addr_width)
  ) u_execute_stage (
    .clock         (clock),
    .rst_n         (rst_n),
    .issue_valid   (issue_valid),
    .issue_op      (issue_op),
    .issue_rd      (issue_rd),
    .issue_imm     (issue_imm),
    .issue_use_imm (issue_use_imm),
    .rdata1        (rdata1),
    .rdata2        (rdata2),
    .ex_valid      (ex_valid),
    .ex_rd         (ex_rd),
    .ex_result     (ex_result),
    .wb_valid      (wb_valid),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data)
  );

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage import exec_pkg::*; #(
  parameter int addr_width = 4
) (
  input  logic                  clock,
  input  logic                  rst_n,
  // issued operation.
  input  logic                  issue_valid,
  input  alu_op_t               issue_op,
  input  logic [addr_width-1:0] issue_rd,
  input  logic [imm_width-1:0]  issue_imm,
  input  logic                  issue_use_imm,
  // bypassed operands from the register file.
  input  logic [xlen-1:0]       rdata1,
  input  logic [xlen-1:0]       rdata2,
  // execute stage state.
  output logic                  ex_valid,
  output logic [addr_width-1:0] ex_rd,
  output logic [xlen-1:0]       ex_result,
  // writeback strobe.
  output logic                  wb_valid,
  output logic [addr_width-1:0] wb_rd,
  output logic [xlen-1:0]       wb_data
);

  logic [xlen-1:0] imm_ext;
  logic [xlen-1:0] operand_b;

  alu_op_t         ex_op;
  logic [xlen-1:0] ex_a;
  logic [xlen-1:0] ex_b;

  // ####################################################################
  // operand select
  // ####################################################################

  assign imm_ext   = {{(xlen-imm_width){issue_imm[imm_width-1]}}, issue_imm};
  assign operand_b = issue_use_imm ? imm_ext : rdata2;

  // ####################################################################
  // execute register
  // ####################################################################

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= issue_valid;
    end
  end

  // payload holds its old value while idle; ex_valid gates the bypass.
  always_ff @(posedge clock) begin
    if (issue_valid) begin
      ex_op <= issue_op;
      ex_rd <= issue_rd;
      ex_a  <= rdata1;
      ex_b  <= operand_b;
    end
  end

  alu u_alu (
    .op     (ex_op),
    .a      (ex_a),
    .b      (ex_b),
    .result (ex_result)
  );

  // ####################################################################
  // writeback register
  // ####################################################################

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex_valid;  // one cycle behind execute.
    end
  end

  always_ff @(posedge clock) begin
    if (ex_valid) begin
      wb_rd   <= ex_rd;
      wb_data <= ex_result;
    end
  end

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/1ns

module register_file import exec_pkg::*; #(
  parameter int addr_width = 4
) (
  input  logic                  clock,
  input  logic [addr_width-1:0] rs1,
  input  logic [addr_width-1:0] rs2,
  // execute stage, the younger bypass source.
  input  logic                  ex_valid,
  input  logic [addr_width-1:0] ex_rd,
  input  logic [xlen-1:0]       ex_result,
  // writeback stage, older bypass source and the write port.
  input  logic                  wb_valid,
  input  logic [addr_width-1:0] wb_rd,
  input  logic [xlen-1:0]       wb_data,
  output logic [xlen-1:0]       rdata1,
  output logic [xlen-1:0]       rdata2
);

  localparam int depth = 2 ** addr_width;

  logic [xlen-1:0] regs [1:depth-1];  // register zero is not stored.
  logic [xlen-1:0] rf   [0:depth-1];  // read view with the hard zero.

  logic ex_fwd_ok;
  logic wb_fwd_ok;

  // ####################################################################
  // storage
  // ####################################################################

  always_ff @(posedge clock) begin
    if (wb_valid && (wb_rd != '0)) begin
      regs[wb_rd] <= wb_data;
    end
  end

  assign rf[0] = '0;

  for (genvar i = 1; i < depth; i++) begin : g_view
    assign rf[i] = regs[i];
  end

  // ####################################################################
  // read ports with bypass
  // ####################################################################

  // a stage with a low valid or a zero rd never forwards.
  assign ex_fwd_ok = ex_valid && (ex_rd != '0);
  assign wb_fwd_ok = wb_valid && (wb_rd != '0);

  // priority: zero, execute result, writeback data, array.
  function automatic logic [xlen-1:0] bypass_read(
    input logic [addr_width-1:0] addr,
    input logic [xlen-1:0]       stored
  );
    logic [xlen-1:0] value;
    if (addr == '0) begin
      value = '0;
    end else if (ex_fwd_ok && (addr == ex_rd)) begin
      value = ex_result;  // younger op wins.
    end else if (wb_fwd_ok && (addr == wb_rd)) begin
      value = wb_data;
    end else begin
      value = stored;
    end
    return value;
  endfunction

  always_comb begin
    rdata1 = bypass_read(rs1, rf[rs1]);
    rdata2 = bypass_read(rs2, rf[rs2]);
  end

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ns

module alu import exec_pkg::*; (
  input  alu_op_t         op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic [xlen-1:0] result
);

  logic [4:0]      shamt;
  logic            lt_signed;
  logic            lt_unsigned;
  logic [xlen-1:0] sum;
  logic [xlen-1:0] diff;

  // ####################################################################
  // shared terms
  // ####################################################################

  assign shamt = b[4:0];  // only the low five bits count.
  assign sum   = a + b;
  assign diff  = a - b;

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  // ####################################################################
  // result select
  // ####################################################################

  always_comb begin
    case (op)
      alu_add: begin
        result = sum;
      end
      alu_sub: begin
        result = diff;
      end
      alu_and:  result = a & b;
      alu_or:   result = a | b;
      alu_xor:  result = a ^ b;
      alu_sll:  result = a << shamt;
      alu_srl:  result = a >> shamt;
      alu_sra: begin
        // sign bit fills from the left.
        result = $unsigned($signed(a) >>> shamt);
      end
      alu_slt: begin
        result = {{(xlen-1){1'b0}}, lt_signed};
      end
      alu_sltu: begin
        result = {{(xlen-1){1'b0}}, lt_unsigned};
      end
      default: begin
        result = '0;  // unused codes.
      end
    endcase
  end

endmodule

// ==== logic/exec_pkg.sv ====
package exec_pkg;

  // ####################################################################
  // widths
  // ####################################################################

  localparam int xlen      = 32;  // data path width.
  localparam int imm_width = 12;  // immediate field, sign extended to xlen.

  // ####################################################################
  // alu operation encoding
  // ####################################################################

  // codes 10 to 15 are unused; the alu returns zero for them.
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,  // shifts take b[4:0].
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,  // signed compare.
    alu_sltu = 4'd9   // unsigned compare.
  } alu_op_t;

endpackage
